//--- verilog/ex_pkg.sv
package ex_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [11:0]     csr_addr_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;

	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// Integer ops, OP and OP-IMM
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101; // SRL and SRA share it
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;

	localparam funct3_t F3_SB = 3'b000;
	localparam funct3_t F3_SH = 3'b001;
	localparam funct3_t F3_SW = 3'b010;

	localparam funct3_t F3_CSRRW  = 3'b001;
	localparam funct3_t F3_CSRRS  = 3'b010;
	localparam funct3_t F3_CSRRC  = 3'b011;
	localparam funct3_t F3_CSRRWI = 3'b101;
	localparam funct3_t F3_CSRRSI = 3'b110;
	localparam funct3_t F3_CSRRCI = 3'b111;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			funct3_t    funct3;
			reg_addr_t  rd;
			opcode_t    opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12;
			reg_addr_t   rs1; // Also the CSR uimm
			funct3_t     funct3;
			reg_addr_t   rd;
			opcode_t     opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			funct3_t    funct3;
			logic [4:0] imm_lo;
			opcode_t    opcode;
		} s_fmt;
	} rv_inst_u;

	typedef struct packed {
		rv_inst_u  inst;
		word_t     inst_addr;
		word_t     op1;
		word_t     op2;
		word_t     op1_jump;
		word_t     op2_jump;
		word_t     reg1_data;
		word_t     reg2_data;
		logic      reg_wr_en;
		reg_addr_t reg_wr_addr;
		logic      csr_wr_en;
		csr_addr_t csr_wr_addr;
		word_t     csr_data; // Current CSR value
	} ex_in_t;

	typedef struct packed {
		logic  req;
		logic  wr_en;
		word_t rd_addr;
		word_t wr_addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic      reg_wr_en;
		reg_addr_t reg_wr_addr;
		word_t     reg_data;
		logic      csr_wr_en;
		csr_addr_t csr_wr_addr;
		word_t     csr_data;
	} wb_t;

	typedef struct packed {
		logic  flag;
		word_t addr;
	} jump_t;

endpackage

//--- verilog/ex_alu.sv
module ex_alu import ex_pkg::*; (
	input  rv_inst_u inst_i,
	input  word_t    op1_i,
	input  word_t    op2_i,
	input  word_t    rs1_data_i,
	input  word_t    rs2_data_i,
	output word_t    result_o,
	output logic     lt_o,
	output logic     ltu_o
);

	logic       is_reg_op;
	logic       alt_op;
	logic [4:0] shamt;
	word_t      sum;
	word_t      diff;
	word_t      sra_res;

	assign is_reg_op = inst_i.r_fmt.opcode == OPC_OP; // Else OP-IMM
	assign alt_op    = inst_i.r_fmt.funct7[5]; // Inst bit 30

	// shamt field for immediates, rs2 for register shifts
	assign shamt = is_reg_op ? rs2_data_i[4:0] : inst_i.i_fmt.imm12[4:0];

	assign sum  = op1_i + op2_i;
	assign diff = op1_i - op2_i;

	assign lt_o  = $signed(op1_i) < $signed(op2_i);
	assign ltu_o = op1_i < op2_i;

	assign sra_res = word_t'($signed(rs1_data_i) >>> shamt); // Source equals op1

	always_comb begin
		case (inst_i.r_fmt.funct3)
			F3_ADD: begin
				if (is_reg_op && alt_op) begin
					result_o = diff;
				end else begin
					result_o = sum; // ADDI ignores bit 30
				end
			end
			F3_SLL:  result_o = rs1_data_i << shamt;
			F3_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_o};
			F3_SLTU: result_o = {{(XLEN-1){1'b0}}, ltu_o};
			F3_XOR:  result_o = op1_i ^ op2_i;
			F3_SR: begin
				if (alt_op) begin
					result_o = sra_res;
				end else begin
					result_o = rs1_data_i >> shamt;
				end
			end
			F3_OR:   result_o = op1_i | op2_i;
			F3_AND:  result_o = op1_i & op2_i;
			default: result_o = '0;
		endcase
	end

endmodule

//--- verilog/ex_branch.sv
module ex_branch import ex_pkg::*; (
	input  rv_inst_u inst_i,
	input  word_t    op1_i,
	input  word_t    op2_i,
	input  word_t    op1_jump_i,
	input  word_t    op2_jump_i,
	input  logic     lt_i,
	input  logic     ltu_i,
	output logic     taken_o,
	output word_t    target_o
);

	logic eq;

	assign eq = op1_i == op2_i;

	// PC-relative or register-relative, formed upstream
	assign target_o = op1_jump_i + op2_jump_i;

	always_comb begin
		case (inst_i.r_fmt.funct3)
			F3_BEQ:  taken_o = eq;
			F3_BNE:  taken_o = !eq;
			F3_BLT:  taken_o = lt_i;
			F3_BGE:  taken_o = !lt_i;
			F3_BLTU: taken_o = ltu_i;
			F3_BGEU: taken_o = !ltu_i;
			default: taken_o = 1'b0; // Reserved encodings
		endcase
	end

endmodule

//--- verilog/ex_lsu.sv
module ex_lsu import ex_pkg::*; (
	input  rv_inst_u inst_i,
	input  word_t    rs1_data_i,
	input  word_t    rs2_data_i,
	input  word_t    mem_rdata_i,
	output word_t    addr_o,
	output word_t    load_data_o,
	output word_t    store_data_o
);

	word_t       imm_i;
	word_t       imm_s;
	logic        is_store;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	assign imm_i = {{(XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
	assign imm_s = {{(XLEN-12){inst_i.s_fmt.imm_hi[6]}},
		inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};

	assign is_store = inst_i.s_fmt.opcode == OPC_STORE;
	assign addr_o   = rs1_data_i + (is_store ? imm_s : imm_i);

	always_comb begin
		case (addr_o[1:0])
			2'd0:    ld_byte = mem_rdata_i[7:0];
			2'd1:    ld_byte = mem_rdata_i[15:8];
			2'd2:    ld_byte = mem_rdata_i[23:16];
			default: ld_byte = mem_rdata_i[31:24];
		endcase
	end

	assign ld_half = addr_o[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

	always_comb begin
		case (inst_i.i_fmt.funct3)
			F3_LB:   load_data_o = {{(XLEN-8){ld_byte[7]}}, ld_byte};
			F3_LH:   load_data_o = {{(XLEN-16){ld_half[15]}}, ld_half};
			F3_LW:   load_data_o = mem_rdata_i;
			F3_LBU:  load_data_o = {{(XLEN-8){1'b0}}, ld_byte};
			F3_LHU:  load_data_o = {{(XLEN-16){1'b0}}, ld_half};
			default: load_data_o = '0;
		endcase
	end

	// Narrow stores overwrite one lane of the word read back
	always_comb begin
		store_data_o = mem_rdata_i;
		case (inst_i.s_fmt.funct3)
			F3_SB: begin
				store_data_o[{addr_o[1:0], 3'b000} +: 8] = rs2_data_i[7:0];
			end
			F3_SH: begin
				store_data_o[{addr_o[1], 4'b0000} +: 16] = rs2_data_i[15:0];
			end
			F3_SW: begin
				store_data_o = rs2_data_i;
			end
			default: begin
				store_data_o = '0;
			end
		endcase
	end

endmodule

//--- verilog/ex_csr.sv
module ex_csr import ex_pkg::*; (
	input  rv_inst_u inst_i,
	input  word_t    rs1_data_i,
	input  word_t    csr_rdata_i,
	output word_t    csr_wdata_o
);

	word_t src;

	// Bit 2 of funct3 marks the uimm forms
	assign src = inst_i.i_fmt.funct3[2] ? {{(XLEN-5){1'b0}}, inst_i.i_fmt.rs1} : rs1_data_i;

	always_comb begin
		case (inst_i.i_fmt.funct3)
			F3_CSRRW, F3_CSRRWI: csr_wdata_o = src;
			F3_CSRRS, F3_CSRRSI: csr_wdata_o = csr_rdata_i | src;
			F3_CSRRC, F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src;
			default:             csr_wdata_o = '0; // ECALL and friends
		endcase
	end

endmodule

//--- verilog/ex_stage.sv
module ex_stage import ex_pkg::*; (
	input  logic     clk,
	input  logic     arst_n_i,
	input  ex_in_t   ex_in_i,
	input  word_t    mem_rdata_i,
	input  logic     irq_i,
	input  word_t    irq_addr_i,
	output mem_req_t mem_o,
	output wb_t      wb_o,
	output jump_t    jump_o
);

	opcode_t  opcode;
	funct3_t  funct3;
	logic     is_load;
	logic     is_store;
	logic     is_branch;
	logic     is_jump;
	logic     is_system;
	logic     ld_ok;
	logic     st_ok;
	logic     csr_ok;
	word_t    alu_result;
	logic     lt;
	logic     ltu;
	logic     br_taken;
	word_t    br_target;
	word_t    ls_addr;
	word_t    load_data;
	word_t    store_data;
	word_t    csr_wdata;
	word_t    reg_data;
	mem_req_t mem_d;
	wb_t      wb_d;
	jump_t    jump_d;

	assign opcode = ex_in_i.inst.r_fmt.opcode;
	assign funct3 = ex_in_i.inst.r_fmt.funct3;

	assign is_load   = opcode == OPC_LOAD;
	assign is_store  = opcode == OPC_STORE;
	assign is_branch = opcode == OPC_BRANCH;
	assign is_jump   = (opcode == OPC_JAL) || (opcode == OPC_JALR);
	assign is_system = opcode == OPC_SYSTEM;

	assign ld_ok  = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
	assign st_ok  = funct3 inside {F3_SB, F3_SH, F3_SW};
	assign csr_ok = funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC,
		F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};

	ex_alu u_alu (
		.inst_i     (ex_in_i.inst),
		.op1_i      (ex_in_i.op1),
		.op2_i      (ex_in_i.op2),
		.rs1_data_i (ex_in_i.reg1_data),
		.rs2_data_i (ex_in_i.reg2_data),
		.result_o   (alu_result),
		.lt_o       (lt),
		.ltu_o      (ltu)
	);

	ex_branch u_branch (
		.inst_i     (ex_in_i.inst),
		.op1_i      (ex_in_i.op1),
		.op2_i      (ex_in_i.op2),
		.op1_jump_i (ex_in_i.op1_jump),
		.op2_jump_i (ex_in_i.op2_jump),
		.lt_i       (lt),
		.ltu_i      (ltu),
		.taken_o    (br_taken),
		.target_o   (br_target)
	);

	ex_lsu u_lsu (
		.inst_i       (ex_in_i.inst),
		.rs1_data_i   (ex_in_i.reg1_data),
		.rs2_data_i   (ex_in_i.reg2_data),
		.mem_rdata_i  (mem_rdata_i),
		.addr_o       (ls_addr),
		.load_data_o  (load_data),
		.store_data_o (store_data)
	);

	ex_csr u_csr (
		.inst_i      (ex_in_i.inst),
		.rs1_data_i  (ex_in_i.reg1_data),
		.csr_rdata_i (ex_in_i.csr_data),
		.csr_wdata_o (csr_wdata)
	);

	always_comb begin
		case (opcode)
			OPC_OP, OPC_OP_IMM:           reg_data = alu_result;
			OPC_JAL, OPC_JALR, OPC_AUIPC: reg_data = ex_in_i.op1 + ex_in_i.op2; // Link or PC+imm
			OPC_LUI:                      reg_data = ex_in_i.op1;
			OPC_LOAD:                     reg_data = load_data;
			OPC_SYSTEM:                   reg_data = csr_ok ? ex_in_i.csr_data : '0;
			default:                      reg_data = '0;
		endcase
	end

	always_comb begin
		mem_d.req     = (is_load && ld_ok) || (is_store && st_ok);
		mem_d.wr_en   = is_store && st_ok;
		mem_d.rd_addr = mem_d.req ? ls_addr : '0;
		mem_d.wr_addr = mem_d.wr_en ? ls_addr : '0;
		mem_d.wdata   = mem_d.wr_en ? store_data : '0;

		wb_d.reg_wr_en   = ex_in_i.reg_wr_en;
		wb_d.reg_wr_addr = ex_in_i.reg_wr_addr;
		wb_d.reg_data    = reg_data;
		wb_d.csr_wr_en   = ex_in_i.csr_wr_en;
		wb_d.csr_wr_addr = ex_in_i.csr_wr_addr;
		wb_d.csr_data    = is_system ? csr_wdata : '0;

		jump_d.flag = is_jump || (is_branch && br_taken);
		jump_d.addr = jump_d.flag ? br_target : '0;

		// Interrupt kills all writes and redirects fetch
		if (irq_i) begin
			mem_d.req      = 1'b0;
			mem_d.wr_en    = 1'b0;
			wb_d.reg_wr_en = 1'b0;
			wb_d.csr_wr_en = 1'b0;
			jump_d.flag    = 1'b1;
			jump_d.addr    = irq_addr_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_o  <= '0;
			wb_o   <= '0;
			jump_o <= '0;
		end else begin
			mem_o  <= mem_d;
			wb_o   <= wb_d;
			jump_o <= jump_d;
		end
	end

endmodule

//--- verif/ex_stage_tb.sv
module ex_stage_tb import ex_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int VEC_WORDS = 18; // 32-bit words per vector line
	localparam int MAX_VEC   = 100;

	logic     clk;
	logic     arst_n_i;
	ex_in_t   ex_in;
	word_t    mem_rdata;
	logic     irq;
	word_t    irq_addr;
	mem_req_t mem_o;
	wb_t      wb_o;
	jump_t    jump_o;

	logic [31:0] vec_mem [0:2047];
	int          num_vec;
	int          errors;
	int          checks;
	int          cycles      = 0;
	int          cycle_limit = 36;
	string       ctx;

	ex_stage dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ex_in_i     (ex_in),
		.mem_rdata_i (mem_rdata),
		.irq_i       (irq),
		.irq_addr_i  (irq_addr),
		.mem_o       (mem_o),
		.wb_o        (wb_o),
		.jump_o      (jump_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the vectors did not finish", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] vec_word(input int v, input int f);
		return vec_mem[11'(v * VEC_WORDS + f)];
	endfunction

	task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error: %s %s = %h, expected %h", ctx, name, act, exp);
		end
	endtask

	task automatic drive_vector(input int v);
		logic [31:0] ctrl;
		ctrl = vec_word(v, 10); // Nibble fields irq wen rd cwen csr
		ex_in.inst        <= vec_word(v, 0);
		ex_in.inst_addr   <= 32'h1000 + 4 * v;
		ex_in.op1         <= vec_word(v, 1);
		ex_in.op2         <= vec_word(v, 2);
		ex_in.op1_jump    <= vec_word(v, 3);
		ex_in.op2_jump    <= vec_word(v, 4);
		ex_in.reg1_data   <= vec_word(v, 5);
		ex_in.reg2_data   <= vec_word(v, 6);
		ex_in.csr_data    <= vec_word(v, 7);
		mem_rdata         <= vec_word(v, 8);
		irq_addr          <= vec_word(v, 9);
		irq               <= ctrl[28];
		ex_in.reg_wr_en   <= ctrl[24];
		ex_in.reg_wr_addr <= ctrl[20:16];
		ex_in.csr_wr_en   <= ctrl[12];
		ex_in.csr_wr_addr <= ctrl[11:0];
	endtask

	task automatic check_vector(input int v);
		logic [31:0] ctrl;
		logic [31:0] flags;
		ctrl  = vec_word(v, 10);
		flags = vec_word(v, 11);
		ctx   = $sformatf("vector %0d", v);
		check_val("mem_o.req", 32'(mem_o.req), 32'(flags[16]));
		check_val("mem_o.wr_en", 32'(mem_o.wr_en), 32'(flags[12]));
		check_val("jump_o.flag", 32'(jump_o.flag), 32'(flags[8]));
		check_val("wb_o.reg_wr_en", 32'(wb_o.reg_wr_en), 32'(flags[4]));
		check_val("wb_o.csr_wr_en", 32'(wb_o.csr_wr_en), 32'(flags[0]));
		check_val("wb_o.reg_wr_addr", 32'(wb_o.reg_wr_addr), 32'(ctrl[20:16])); // Pass-through
		check_val("wb_o.csr_wr_addr", 32'(wb_o.csr_wr_addr), 32'(ctrl[11:0]));
		check_val("mem_o.rd_addr", mem_o.rd_addr, vec_word(v, 12));
		check_val("mem_o.wr_addr", mem_o.wr_addr, vec_word(v, 13));
		check_val("mem_o.wdata", mem_o.wdata, vec_word(v, 14));
		check_val("wb_o.reg_data", wb_o.reg_data, vec_word(v, 15));
		check_val("wb_o.csr_data", wb_o.csr_data, vec_word(v, 16));
		check_val("jump_o.addr", jump_o.addr, vec_word(v, 17));
	endtask

	initial begin
		clk       = 1'b0;
		arst_n_i  = 1'b0;
		ex_in     = '0;
		mem_rdata = '0;
		irq       = 1'b0;
		irq_addr  = '0;
		errors    = 0;
		checks    = 0;

		ex_in.inst      = 32'h0020a023; // SW with both enables held in reset
		ex_in.reg_wr_en = 1'b1;
		ex_in.csr_wr_en = 1'b1;

		$readmemh("verif/ex_tests.mem", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_word(num_vec, 0) !== 32'hffff_ffff) begin
			num_vec++; // Stops at the end marker line
		end
		if (num_vec == 0 || num_vec == MAX_VEC) begin
			errors++;
			$display("The vector file is missing, empty or has no end marker");
			num_vec = 0;
		end
		cycle_limit = num_vec + 16 + 20;

		repeat (16) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		ctx = "after reset";
		check_val("mem_o.req", 32'(mem_o.req), 32'h0);
		check_val("mem_o.wr_en", 32'(mem_o.wr_en), 32'h0);
		check_val("wb_o.reg_wr_en", 32'(wb_o.reg_wr_en), 32'h0);
		check_val("wb_o.csr_wr_en", 32'(wb_o.csr_wr_en), 32'h0);
		check_val("jump_o.flag", 32'(jump_o.flag), 32'h0);

		// One cycle latency so vector k-1 is checked while k is driven
		for (int k = 0; k <= num_vec; k++) begin
			@(posedge clk);
			if (k < num_vec) begin
				drive_vector(k);
			end
			@(negedge clk);
			if (k > 0) begin
				check_vector(k - 1);
			end
		end

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verif/ex_tests.mem
// in: inst op1 op2 op1_jump op2_jump reg1 reg2 csr_rdata mem_rdata irq_addr ctrl(irq,wen,rd,cwen,csr)
// exp: flags(req,wr_en,jump,wen,cwen) rd_addr wr_addr wdata reg_data csr_data jump_addr
002081B3 12345678 11111111 0 0 12345678 11111111 0 0 0 01030000 00010 0 0 0 23456789 0 0
402081B3 3 5 0 0 3 5 0 0 0 01030000 00010 0 0 0 FFFFFFFE 0 0
002091B3 F 24 0 0 F 24 0 0 0 01030000 00010 0 0 0 F0 0 0
0020A1B3 FFFFFFF0 1 0 0 FFFFFFF0 1 0 0 0 01030000 00010 0 0 0 1 0 0
0020B1B3 FFFFFFF0 1 0 0 FFFFFFF0 1 0 0 0 01030000 00010 0 0 0 0 0 0
0020C1B3 F0F0F0F0 FF00FF00 0 0 F0F0F0F0 FF00FF00 0 0 0 01030000 00010 0 0 0 0FF00FF0 0 0
0020D1B3 80000000 1F 0 0 80000000 1F 0 0 0 01030000 00010 0 0 0 1 0 0
4020D1B3 80000000 4 0 0 80000000 4 0 0 0 01030000 00010 0 0 0 F8000000 0 0
0020E1B3 F000 F0 0 0 F000 F0 0 0 0 01030000 00010 0 0 0 F0F0 0 0
0020F1B3 12345678 FFFF 0 0 12345678 FFFF 0 0 0 01030000 00010 0 0 0 5678 0 0
FFF08193 10 FFFFFFFF 0 0 10 0 0 0 0 01030000 00010 0 0 0 F 0 0
FFF0A193 FFFFFFF0 FFFFFFFF 0 0 FFFFFFF0 0 0 0 0 01030000 00010 0 0 0 1 0 0
FFF0B193 10 FFFFFFFF 0 0 10 0 0 0 0 01030000 00010 0 0 0 1 0 0
0FF0C193 F0F0 FF 0 0 F0F0 0 0 0 0 01030000 00010 0 0 0 F00F 0 0
00F0E193 100 F 0 0 100 0 0 0 0 01030000 00010 0 0 0 10F 0 0
0F00F193 12345678 F0 0 0 12345678 0 0 0 0 01030000 00010 0 0 0 70 0 0
00809193 AB 8 0 0 AB 0 0 0 0 01030000 00010 0 0 0 AB00 0 0
0040D193 F0000000 4 0 0 F0000000 0 0 0 0 01030000 00010 0 0 0 0F000000 0 0
4040D193 F0000000 4 0 0 F0000000 0 0 0 0 01030000 00010 0 0 0 FF000000 0 0
123451B7 12345000 0 0 0 0 0 0 0 0 01030000 00010 0 0 0 12345000 0 0
00001197 400 1000 0 0 0 0 0 0 0 01030000 00010 0 0 0 1400 0 0
00208863 5 5 100 10 5 5 0 0 0 00000000 00100 0 0 0 0 0 110
00208863 5 6 100 10 5 6 0 0 0 00000000 00000 0 0 0 0 0 0
00209863 5 6 100 10 5 6 0 0 0 00000000 00100 0 0 0 0 0 110
00209863 5 5 100 10 5 5 0 0 0 00000000 00000 0 0 0 0 0 0
0020C863 FFFFFFFF 1 100 10 FFFFFFFF 1 0 0 0 00000000 00100 0 0 0 0 0 110
0020C863 1 FFFFFFFF 100 10 1 FFFFFFFF 0 0 0 00000000 00000 0 0 0 0 0 0
0020D863 1 FFFFFFFF 100 10 1 FFFFFFFF 0 0 0 00000000 00100 0 0 0 0 0 110
0020D863 FFFFFFFF 1 100 10 FFFFFFFF 1 0 0 0 00000000 00000 0 0 0 0 0 0
0020E863 1 FFFFFFFF 100 10 1 FFFFFFFF 0 0 0 00000000 00100 0 0 0 0 0 110
0020E863 FFFFFFFF 1 100 10 FFFFFFFF 1 0 0 0 00000000 00000 0 0 0 0 0 0
0020F863 FFFFFFFF 1 100 10 FFFFFFFF 1 0 0 0 00000000 00100 0 0 0 0 0 110
0020F863 1 FFFFFFFF 100 10 1 FFFFFFFF 0 0 0 00000000 00000 0 0 0 0 0 0
020000EF 200 4 200 20 0 0 0 0 0 01010000 00110 0 0 0 204 0 220
008280E7 300 4 1000 8 1000 0 0 0 0 01010000 00110 0 0 0 304 0 1008
00008183 2000 0 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2000 0 0 5A 0 0
00108183 2000 1 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2001 0 0 FFFFFFA5 0 0
00208183 2000 2 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2002 0 0 FFFFFF8C 0 0
00308183 2000 3 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2003 0 0 7B 0 0
0010C183 2000 1 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2001 0 0 A5 0 0
00009183 2000 0 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2000 0 0 FFFFA55A 0 0
00209183 2000 2 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2002 0 0 7B8C 0 0
0000D183 2000 0 0 0 2000 0 0 7B8CA55A 0 01030000 10010 2000 0 0 A55A 0 0
FFC0A183 2004 FFFFFFFC 0 0 2004 0 0 7B8CA55A 0 01030000 10010 2000 0 0 7B8CA55A 0 0
FE20AC23 3008 FFFFFFF8 0 0 3008 AABBCCDD 0 11223344 80 11031300 00100 3000 3000 AABBCCDD 0 0 80
FE20AC23 3008 FFFFFFF8 0 0 3008 AABBCCDD 0 11223344 0 00000000 11000 3000 3000 AABBCCDD 0 0 0
002080A3 3000 1 0 0 3000 AABBCCDD 0 11223344 0 00000000 11000 3001 3001 1122DD44 0 0 0
002081A3 3000 3 0 0 3000 AABBCCDD 0 11223344 0 00000000 11000 3003 3003 DD223344 0 0 0
00209123 3000 2 0 0 3000 AABBCCDD 0 11223344 0 00000000 11000 3002 3002 CCDD3344 0 0 0
300091F3 0 0 0 0 F 0 F0 0 0 01031300 00011 0 0 0 F0 F 0
3000A1F3 0 0 0 0 F 0 F0 0 0 01031300 00011 0 0 0 F0 FF 0
3000B1F3 0 0 0 0 30 0 F0 0 0 01031300 00011 0 0 0 F0 C0 0
300AD1F3 0 0 0 0 FFFFFFFF 0 F0 0 0 01031300 00011 0 0 0 F0 15 0
300AE1F3 0 0 0 0 FFFFFFFF 0 F0 0 0 01031300 00011 0 0 0 F0 F5 0
300AF1F3 0 0 0 0 FFFFFFFF 0 FF 0 0 01031300 00011 0 0 0 FF EA 0
FFFFFFFF

//--- build.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_lsu.sv
verilog/ex_csr.sv
verilog/ex_stage.sv
verif/ex_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --timescale 1ns/100ps \
	--top-module ex_stage_tb -Mdir "$obj" -o ex_stage_sim -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"./$obj/ex_stage_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if [ ! -s "$log" ]; then
	echo "Simulation log is missing or empty"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
	exit 1
fi
exit 0
